// File: aluUnit.f
hdl/aluPkg.sv
hdl/aluDecode.sv
hdl/aluExecute.sv
hdl/aluResult.sv
hdl/aluUnit.sv
test/aluUnit_asserts.sv
test/aluUnitTb.sv

// File: runSim.sh
#!/bin/sh
# builds the aluUnit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module aluUnitTb -f aluUnit.f -o aluUnitSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit 1
fi

./obj_dir/aluUnitSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "SOME TESTS FAILED" "$logFile"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

exit 0

// File: test/aluUnitTb.sv
`timescale 1ns/10ps

module aluUnitTb;
  import aluPkg::*;

  logic       clock;
  logic       reset;
  logic       req;
  aluRequest  request;
  logic       ack;
  aluResponse response;

  integer     seed;
  aluResponse expectQ[$]; // one entry per request still waiting for ack
  int         issued;
  int         compared;
  logic       ackLast;

  aluUnit u_dut (
    .clock    (clock),
    .reset    (reset),
    .req      (req),
    .request  (request),
    .ack      (ack),
    .response (response)
  );

  always #5 clock = ~clock;

  // ========================================
  // reference model
  // ========================================
  function automatic aluResponse aluModel(input aluRequest stim);
    aluResponse         rsp;
    logic [32:0]        wide;
    logic signed [32:0] exact;
    logic [31:0]        a;
    logic [31:0]        b;
    aluShiftCtrl        ctrl;
    a    = stim.operandA;
    b    = stim.operandB.data;
    ctrl = stim.operandB.shift;
    rsp  = '0;
    case (stim.command)
      cmdAdd: begin
        wide         = {1'b0, a} + {1'b0, b};
        exact        = $signed({a[31], a}) + $signed({b[31], b});
        rsp.result   = wide[31:0];
        rsp.carryout = wide[32];
        rsp.overflow = (exact[32] != exact[31]); // true sum does not fit in 32 signed bits
      end
      cmdSub: begin
        exact        = $signed({a[31], a}) - $signed({b[31], b});
        rsp.result   = a - b;
        rsp.carryout = (a >= b); // carry out of A plus not B plus one means no borrow
        rsp.overflow = (exact[32] != exact[31]);
      end
      cmdSlt:  rsp.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cmdXor:  rsp.result = a ^ b;
      cmdAnd:  rsp.result = a & b;
      cmdNand: rsp.result = ~(a & b);
      cmdNor:  rsp.result = ~(a | b);
      cmdOr:   rsp.result = a | b;
      cmdShift: begin
        if (!ctrl.right) rsp.result = a << ctrl.amount;
        else if (ctrl.arithmetic) rsp.result = $signed(a) >>> ctrl.amount;
        else rsp.result = a >> ctrl.amount;
      end
      default: rsp.result = 32'd0;
    endcase
    rsp.zero = (rsp.result == 32'd0); // the zero flag follows the result for every command
    return rsp;
  endfunction

  function automatic aluRequest makeRequest(input logic [3:0] code, input logic [31:0] a,
                                            input logic [31:0] b);
    aluRequest stim;
    stim.operandA      = a;
    stim.operandB.data = b;
    stim.command       = aluCommand'(code);
    return stim;
  endfunction

  // ========================================
  // error reporting
  // ========================================
  task automatic failRun();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic stopWithError(input string what);
    $display("ERROR at %0t: %s", $time, what);
    failRun();
  endtask

  task automatic reportMismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
    failRun();
  endtask

  task automatic checkResponse(input aluResponse expected);
    assert (response.result == expected.result)
      else reportMismatch("response.result", 64'(expected.result), 64'(response.result));
    assert (response.carryout == expected.carryout)
      else reportMismatch("response.carryout", 64'(expected.carryout), 64'(response.carryout));
    assert (response.overflow == expected.overflow)
      else reportMismatch("response.overflow", 64'(expected.overflow), 64'(response.overflow));
    assert (response.zero == expected.zero)
      else reportMismatch("response.zero", 64'(expected.zero), 64'(response.zero));
  endtask

  // compares on the first falling edge that sees ack high
  always @(negedge clock) begin
    if (reset) begin
      ackLast = 1'b0;
    end else begin
      if (ack && !ackLast) begin
        assert (expectQ.size() > 0) else stopWithError("ack rose with no request outstanding");
        checkResponse(expectQ.pop_front());
        compared++;
      end
      ackLast = ack;
    end
  end

  // one full four phase cycle
  task automatic runTransaction(input aluRequest stim);
    int cycles;
    request = stim;
    req     = 1'b1;
    expectQ.push_back(aluModel(stim));
    issued++;
    cycles = 0;
    while (!ack && cycles < 50) begin
      @(negedge clock);
      cycles++;
    end
    assert (ack) else stopWithError("ack never rose");
    assert (cycles == 3) else reportMismatch("ack rise latency", 64'(3), 64'(cycles));
    req    = 1'b0;
    cycles = 0;
    while (ack && cycles < 50) begin
      @(negedge clock);
      cycles++;
    end
    assert (!ack) else stopWithError("ack never fell");
    assert (cycles == 1) else reportMismatch("ack fall latency", 64'(1), 64'(cycles));
  endtask

  // ========================================
  // stimulus
  // ========================================
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    aluOperandB  shiftB;
    logic [3:0]  logicCodes [5];
    clock      = 1'b0;
    reset      = 1'b1;
    req        = 1'b0;
    request    = '0;
    seed       = 32'hcdbf;
    issued     = 0;
    compared   = 0;
    logicCodes = '{cmdXor, cmdAnd, cmdNand, cmdNor, cmdOr};
    repeat (3) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    assert (ack == 1'b0) else reportMismatch("ack", 64'(0), 64'(ack));
    assert (response == '0) else reportMismatch("response", 64'(0), 64'(response));

    runTransaction(makeRequest(cmdAdd, 32'h7fffffff, 32'h00000001)); // signed overflow
    runTransaction(makeRequest(cmdAdd, 32'hffffffff, 32'h00000001)); // carry with zero
    runTransaction(makeRequest(cmdSub, 32'h00000000, 32'h00000001));
    runTransaction(makeRequest(cmdSub, 32'h80000000, 32'h00000001));
    a = $random(seed);
    runTransaction(makeRequest(cmdSub, a, a));
    runTransaction(makeRequest(cmdAdd, a, -a));
    repeat (20) begin
      a = $random(seed);
      b = $random(seed);
      runTransaction(makeRequest(cmdAdd, a, b));
      runTransaction(makeRequest(cmdSub, a, b));
    end

    foreach (logicCodes[i]) begin
      repeat (10) begin
        a = $random(seed);
        b = $random(seed);
        runTransaction(makeRequest(logicCodes[i], a, b));
      end
      a = $random(seed);
      runTransaction(makeRequest(logicCodes[i], a, ~a)); // AND and NOR give zero here
      runTransaction(makeRequest(logicCodes[i], a, a));
    end

    runTransaction(makeRequest(cmdSlt, 32'hfffffff0, 32'h00000010));
    runTransaction(makeRequest(cmdSlt, 32'h00000010, 32'hfffffff0));
    runTransaction(makeRequest(cmdSlt, 32'h80000000, 32'h7fffffff));
    runTransaction(makeRequest(cmdSlt, 32'h7fffffff, 32'h80000000));
    runTransaction(makeRequest(cmdSlt, a, a));
    repeat (20) begin
      a = $random(seed);
      b = $random(seed);
      runTransaction(makeRequest(cmdSlt, a, b));
    end

    // left, right logical and right arithmetic over every amount
    for (int mode = 0; mode < 3; mode++) begin
      for (int amt = 0; amt < 32; amt++) begin
        a                       = $random(seed);
        shiftB.data             = $random(seed);
        shiftB.shift.right      = (mode != 0);
        shiftB.shift.arithmetic = (mode == 2) ? 1'b1 : (mode == 0 && shiftB.data[6]);
        shiftB.shift.amount     = 5'(amt);
        runTransaction(makeRequest(cmdShift, a, shiftB.data));
      end
    end
    repeat (20) begin
      a = $random(seed);
      b = $random(seed);
      runTransaction(makeRequest(cmdShift, a, b));
    end

    for (int code = 9; code < 16; code++) begin
      a = $random(seed);
      b = $random(seed);
      runTransaction(makeRequest(4'(code), a, b));
    end

    if (expectQ.size() == 0 && compared == issued) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stopWithError("not every request got a checked response");
    end
  end

endmodule

// File: test/aluUnit_asserts.sv
`timescale 1ns/10ps

module aluUnitAsserts (
  input logic               clock,
  input logic               reset,
  input logic               req,
  input logic               ack,
  input aluPkg::aluResponse response
);
  import aluPkg::*;

  // ack answers a request that was still held on the edge that raised it
  ackNeedsReq: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  ackFallsAfterReq: assert property (@(posedge clock) disable iff (reset)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  zeroFlagMatches: assert property (@(posedge clock) disable iff (reset)
    ack |-> (response.zero == (response.result == {dataWidth{1'b0}})))
    else $error("zero flag does not match the result");

endmodule

bind aluUnit aluUnitAsserts u_asserts (
  .clock    (clock),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .response (response)
);

// File: hdl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
  input  logic               clock,
  input  logic               reset,
  input  logic               req,
  input  aluPkg::aluRequest  request,
  output logic               ack,
  output aluPkg::aluResponse response
);
  import aluPkg::*;

  aluDecoded  decoded;
  logic       decodedValid;
  aluResponse rawResponse;
  logic       rawValid;

  // ========================================
  // three registered stages
  // ========================================
  aluDecode u_decode (
    .clock        (clock),
    .reset        (reset),
    .req          (req),
    .request      (request),
    .decoded      (decoded),
    .decodedValid (decodedValid)
  );

  aluExecute u_execute (
    .clock        (clock),
    .reset        (reset),
    .decoded      (decoded),
    .decodedValid (decodedValid),
    .rawResponse  (rawResponse),
    .rawValid     (rawValid)
  );

  // only this stage looks at req again, to finish the four phase cycle
  aluResult u_result (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .rawResponse (rawResponse),
    .rawValid    (rawValid),
    .ack         (ack),
    .response    (response)
  );

endmodule

// File: hdl/aluResult.sv
`timescale 1ns/10ps

module aluResult (
  input  logic               clock,
  input  logic               reset,
  input  logic               req,
  input  aluPkg::aluResponse rawResponse,
  input  logic               rawValid,
  output logic               ack,
  output aluPkg::aluResponse response
);
  import aluPkg::*;

  logic       resultIsZero;
  aluResponse finalResponse;

  // ========================================
  // zero flag
  // ========================================
  assign resultIsZero = (rawResponse.result == {dataWidth{1'b0}});

  always_comb begin
    finalResponse      = rawResponse;
    finalResponse.zero = resultIsZero;
  end

  // ========================================
  // handshake
  // ========================================
  // ack goes high one cycle after rawValid and stays up while req is held,
  // which is the only back-pressure the unit has
  always_ff @(posedge clock) begin
    if (reset) begin
      ack      <= 1'b0;
      response <= '0;
    end else if (rawValid) begin
      ack      <= 1'b1;
      response <= finalResponse; // held until the next transaction
    end else if (ack && !req) begin
      ack <= 1'b0; // requester has dropped req, close the cycle
    end
  end

endmodule

// File: hdl/aluExecute.sv
`timescale 1ns/10ps

module aluExecute (
  input  logic               clock,
  input  logic               reset,
  input  aluPkg::aluDecoded  decoded,
  input  logic               decodedValid,
  output aluPkg::aluResponse rawResponse,
  output logic               rawValid
);
  import aluPkg::*;

  logic [dataWidth-1:0] operandA;
  logic [dataWidth-1:0] operandB;
  aluShiftCtrl          shiftCtrl;

  logic [dataWidth-1:0] addendB;
  logic [dataWidth:0]   sum;
  logic                 addOverflow;
  logic                 lessThan;

  logic [dataWidth-1:0] logicRaw;
  logic [dataWidth-1:0] logicResult;
  logic [dataWidth-1:0] shiftResult;

  aluResponse           nextResponse;

  assign operandA  = decoded.operandA;
  assign operandB  = decoded.operandB.data;
  assign shiftCtrl = decoded.operandB.shift; // same word, read as shift control

  // ========================================
  // adder and subtractor
  // ========================================
  // subtraction is A plus not B plus one, the one enters as carry in
  assign addendB = decoded.subtract ? ~operandB : operandB;
  assign sum     = {1'b0, operandA} + {1'b0, addendB} + {{dataWidth{1'b0}}, decoded.subtract};

  // operands of equal sign giving a sum of the other sign
  assign addOverflow = (operandA[dataWidth-1] == addendB[dataWidth-1]) &&
                       (sum[dataWidth-1] != operandA[dataWidth-1]);

  // the sign of A minus B is wrong exactly when the subtraction overflowed
  assign lessThan = sum[dataWidth-1] ^ addOverflow;

  // ========================================
  // logic unit
  // ========================================
  always_comb begin
    case (decoded.logicFn)
      logicAnd: logicRaw = operandA & operandB;
      logicOr:  logicRaw = operandA | operandB;
      logicXor: logicRaw = operandA ^ operandB;
      default:  logicRaw = '0;
    endcase
    logicResult = decoded.invert ? ~logicRaw : logicRaw; // NAND and NOR
  end

  // ========================================
  // shifter
  // ========================================
  always_comb begin
    if (!shiftCtrl.right) begin
      shiftResult = operandA << shiftCtrl.amount; // arithmetic bit has no effect here
    end else if (shiftCtrl.arithmetic) begin
      shiftResult = $unsigned($signed(operandA) >>> shiftCtrl.amount);
    end else begin
      shiftResult = operandA >> shiftCtrl.amount;
    end
  end

  // ========================================
  // result select
  // ========================================
  always_comb begin
    nextResponse = '0; // zero flag stays clear, the result stage sets it
    case (decoded.unit)
      unitAdder: begin
        if (decoded.setLess) begin
          nextResponse.result = {{(dataWidth-1){1'b0}}, lessThan};
        end else begin
          nextResponse.result   = sum[dataWidth-1:0];
          nextResponse.carryout = sum[dataWidth];
          nextResponse.overflow = addOverflow;
        end
      end
      unitLogic: begin
        nextResponse.result = logicResult;
      end
      unitShift: begin
        nextResponse.result = shiftResult;
      end
      default: begin
        nextResponse = '0; // undefined command
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rawValid <= 1'b0;
    end else begin
      rawValid <= decodedValid;
    end
  end

  always_ff @(posedge clock) begin
    if (decodedValid) begin
      rawResponse <= nextResponse;
    end
  end

endmodule

// File: hdl/aluDecode.sv
`timescale 1ns/10ps

module aluDecode (
  input  logic              clock,
  input  logic              reset,
  input  logic              req,
  input  aluPkg::aluRequest request,
  output aluPkg::aluDecoded decoded,
  output logic              decodedValid
);
  import aluPkg::*;

  logic      reqLast;
  logic      reqRise;
  aluDecoded nextDecoded;

  // a new transaction starts only on a low to high step of req
  assign reqRise = req && !reqLast;

  // ========================================
  // command decode
  // ========================================
  always_comb begin
    nextDecoded          = '0;
    nextDecoded.operandA = request.operandA;
    nextDecoded.operandB = request.operandB;
    nextDecoded.unit     = unitNone; // codes 9 to 15 fall through to here
    nextDecoded.logicFn  = logicAnd;
    case (request.command)
      cmdAdd: begin
        nextDecoded.unit = unitAdder;
      end
      cmdSub: begin
        nextDecoded.unit     = unitAdder;
        nextDecoded.subtract = 1'b1;
      end
      cmdSlt: begin
        // SLT reuses the subtractor and looks at the corrected sign
        nextDecoded.unit     = unitAdder;
        nextDecoded.subtract = 1'b1;
        nextDecoded.setLess  = 1'b1;
      end
      cmdXor: begin
        nextDecoded.unit    = unitLogic;
        nextDecoded.logicFn = logicXor;
      end
      cmdAnd: begin
        nextDecoded.unit    = unitLogic;
        nextDecoded.logicFn = logicAnd;
      end
      cmdNand: begin
        nextDecoded.unit    = unitLogic;
        nextDecoded.logicFn = logicAnd;
        nextDecoded.invert  = 1'b1;
      end
      cmdNor: begin
        nextDecoded.unit    = unitLogic;
        nextDecoded.logicFn = logicOr;
        nextDecoded.invert  = 1'b1;
      end
      cmdOr: begin
        nextDecoded.unit    = unitLogic;
        nextDecoded.logicFn = logicOr;
      end
      cmdShift: begin
        nextDecoded.unit = unitShift;
      end
      default: begin
        nextDecoded.unit = unitNone;
      end
    endcase
  end

  // ========================================
  // capture register
  // ========================================
  always_ff @(posedge clock) begin
    if (reset) begin
      reqLast      <= 1'b0;
      decodedValid <= 1'b0;
    end else begin
      reqLast      <= req;
      decodedValid <= reqRise; // one cycle pulse per transaction
    end
  end

  always_ff @(posedge clock) begin
    if (reqRise) begin
      decoded <= nextDecoded;
    end
  end

endmodule

// File: hdl/aluPkg.sv
package aluPkg;

  // ========================================
  // widths
  // ========================================
  localparam int dataWidth = 32;
  localparam int shiftBits = 5;

  // logic unit function select, inversion is applied afterwards
  localparam logic [1:0] logicAnd = 2'd0;
  localparam logic [1:0] logicOr  = 2'd1;
  localparam logic [1:0] logicXor = 2'd2;

  // ========================================
  // commands and operands
  // ========================================
  typedef enum logic [3:0] {
    cmdAdd   = 4'd0,
    cmdSub   = 4'd1,
    cmdXor   = 4'd2,
    cmdSlt   = 4'd3,
    cmdAnd   = 4'd4,
    cmdNand  = 4'd5,
    cmdNor   = 4'd6,
    cmdOr    = 4'd7,
    cmdShift = 4'd8 // the shift is why the command needs a fourth bit
  } aluCommand;

  // operand B as seen by the shifter
  typedef struct packed {
    logic [dataWidth-shiftBits-3:0] padding;
    logic                           arithmetic; // sign fill on a right shift
    logic                           right;
    logic [shiftBits-1:0]           amount;
  } aluShiftCtrl;

  typedef union packed {
    logic [dataWidth-1:0] data;
    aluShiftCtrl          shift;
  } aluOperandB;

  typedef struct packed {
    logic [dataWidth-1:0] operandA;
    aluOperandB           operandB;
    aluCommand            command;
  } aluRequest;

  // ========================================
  // stage payloads
  // ========================================
  typedef enum logic [1:0] {
    unitAdder,
    unitLogic,
    unitShift,
    unitNone
  } aluUnitSel;

  typedef struct packed {
    logic [dataWidth-1:0] operandA;
    aluOperandB           operandB;
    aluUnitSel            unit;
    logic                 subtract;
    logic                 setLess; // take the SLT bit instead of the sum
    logic [1:0]           logicFn;
    logic                 invert;
  } aluDecoded;

  typedef struct packed {
    logic [dataWidth-1:0] result;
    logic                 carryout;
    logic                 zero;
    logic                 overflow;
  } aluResponse;

endpackage
